// File: Makefile
# Verilator build and run of the framer testbench
SIM  := obj_dir/Vtb_aurora_tx_framer
SRCS := $(filter %.sv %.v,$(shell cat sim.f))

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

# Rebuilt only when the file list or a listed source changes
$(SIM): sim.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_aurora_tx_framer -f sim.f

clean:
	rm -rf obj_dir

// File: bench/tb_aurora_tx_framer.sv
module tb_aurora_tx_framer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         PKT_BITS    = 256;
    localparam logic [7:0] PARTNER_ID  = 8'h01;   // Packets from this FPGA are dropped
    localparam int         DRAIN_LIMIT = 20000;   // Cycles one test may take to empty out
    localparam int         PATTERN_LEN = 1024;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } beat_t;

    logic                user_clk;
    logic                reset_TX_RX_Block;
    logic                empty = 1'b1;
    logic                rd_en;
    logic [PKT_BITS-1:0] dout = '0;
    logic [31:0]         s_axi_tx_tdata;
    logic                s_axi_tx_tvalid;
    logic                s_axi_tx_tlast;
    logic                s_axi_tx_tready = 1'b1;

    logic [PKT_BITS-1:0] fifo_q [$];        // Show-ahead FIFO, head at index 0
    beat_t               exp_q [$];         // Beats the link should still accept
    bit                  ready_pattern [PATTERN_LEN];
    bit                  random_ready = 1'b0;   // Link side follows ready_pattern
    bit                  quiet_check  = 1'b0;   // Outputs must stay low meanwhile
    logic [7:0]          exp_seq = '0;           // Next sequence number to expect
    int                  ready_idx = 0;
    int                  error_count = 0;
    int                  pushed = 0;
    int                  popped = 0;
    int                  beats_checked = 0;

    // What the link saw on the previous falling edge
    logic [31:0] shown_data  = '0;
    logic        shown_valid = 1'b0;
    logic        shown_last  = 1'b0;
    logic        shown_ready = 1'b1;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clk_gen (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block)
    );

    aurora_tx_framer #(.PACKET_SIZE_BITS(PKT_BITS), .TARGET_FPGA_ID(PARTNER_ID)) dut0 (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .rd_en             (rd_en),
        .dout              (dout),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast),
        .s_axi_tx_tready   (s_axi_tx_tready)
    );

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        error_count++;
        $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_problem(string what);
        error_count++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic end_run();
        $display("Totals: %0d packets queued, %0d popped, %0d beats checked, %0d errors",
                 pushed, popped, beats_checked, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic print_test_line(string name);
        $display("Test %s finished: %0d packets, %0d beats checked, %0d errors so far",
                 name, pushed, beats_checked, error_count);
    endtask

    ////////////////////////////////////////////////////////////
    // FIFO model
    ////////////////////////////////////////////////////////////

    always @(posedge user_clk) begin
        if (rd_en === 1'b1 && fifo_q.size() != 0) begin
            fifo_q.delete(0);          // Pop happens on the edge that sees rd_en
            popped <= popped + 1;
        end
    end

    always @(negedge user_clk) begin
        empty = (fifo_q.size() == 0);
        if (fifo_q.size() != 0) dout = fifo_q[0];   // Head packet is always on show
    end

    ////////////////////////////////////////////////////////////
    // Link side: beat checks, stall hold and tready
    ////////////////////////////////////////////////////////////

    task automatic check_beat(logic [31:0] data, logic last);
        beat_t exp;
        if (exp_q.size() == 0) begin
            report_problem("link accepted a beat with no packet left to send");
        end else begin
            exp = exp_q.pop_front();
            beats_checked++;
            assert (data == exp.data)
                else report_mismatch("s_axi_tx_tdata", exp.data, data);
            assert (last == exp.last)
                else report_mismatch("s_axi_tx_tlast", {31'b0, exp.last}, {31'b0, last});
        end
    endtask

    always @(negedge user_clk) begin
        // Beat shown last cycle was taken on the rising edge just gone
        if (shown_valid && shown_ready) check_beat(shown_data, shown_last);
        if (!shown_ready) begin   // Stalled edge, nothing may move
            assert (s_axi_tx_tdata == shown_data)
                else report_mismatch("s_axi_tx_tdata", shown_data, s_axi_tx_tdata);
            assert (s_axi_tx_tvalid == shown_valid)
                else report_mismatch("s_axi_tx_tvalid", {31'b0, shown_valid},
                                     {31'b0, s_axi_tx_tvalid});
            assert (s_axi_tx_tlast == shown_last)
                else report_mismatch("s_axi_tx_tlast", {31'b0, shown_last},
                                     {31'b0, s_axi_tx_tlast});
        end
        shown_data      = s_axi_tx_tdata;
        shown_valid     = s_axi_tx_tvalid;
        shown_last      = s_axi_tx_tlast;
        s_axi_tx_tready = random_ready ? ready_pattern[ready_idx] : 1'b1;
        shown_ready     = s_axi_tx_tready;
        ready_idx       = (ready_idx + 1) % PATTERN_LEN;
    end

    // Port rules that hold on every edge outside reset
    a_pop_once : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        rd_en |=> !rd_en)
        else report_problem("rd_en stayed high for a second cycle");

    a_pop_nonempty : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        rd_en |-> !empty)
        else report_problem("rd_en raised while the FIFO was empty");

    a_last_valid : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        s_axi_tx_tlast |-> s_axi_tx_tvalid)
        else report_problem("tlast raised without tvalid");

    a_quiet : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        quiet_check |-> !rd_en && !s_axi_tx_tvalid && !s_axi_tx_tlast)
        else report_problem("rd_en, tvalid or tlast high after reset with the FIFO empty");

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Builds one packet, queues it and lists the beats it should produce
    task automatic queue_packet(logic [7:0] src_id, int count);
        logic [PKT_BITS-1:0] pkt;
        beat_t               b;
        for (int i = 0; i < PKT_BITS / 32; i++) pkt[i*32 +: 32] = $urandom;
        pkt[PKT_BITS-9 -: 8]   = src_id;          // Source id under the bus id byte
        pkt[PKT_BITS-49 -: 16] = 16'(count * 4);  // Valid bytes, low two bits zero
        fifo_q.push_back(pkt);
        pushed++;
        if (src_id != PARTNER_ID && count != 0) begin
            for (int i = 0; i < count + 2; i++) begin
                b.data = pkt[PKT_BITS-1-32*i -: 32];
                if (i == 0) b.data[31:24] = exp_seq;   // Bus id becomes the sequence number
                b.last = (i == count + 1);
                exp_q.push_back(b);
            end
            exp_seq++;   // Only sent packets take a number
        end
    endtask

    task automatic wait_drained(string name, output bit ok);
        int cycles;
        cycles = 0;
        while ((popped != pushed || exp_q.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(posedge user_clk);
            cycles++;
        end
        if (popped != pushed || exp_q.size() != 0) begin
            report_problem($sformatf("timeout in %s with %0d packets unread and %0d beats unsent",
                                     name, pushed - popped, exp_q.size()));
            ok = 1'b0;
        end else begin
            print_test_line(name);
            ok = 1'b1;
        end
    endtask

    task automatic run_random(string name, int packets, bit ready_random, output bit ok);
        logic [7:0] src;
        random_ready = ready_random;
        for (int n = 0; n < packets; n++) begin
            src = ($urandom % 4 == 0) ? PARTNER_ID : 8'($urandom);
            queue_packet(src, int'($urandom % 7));
        end
        wait_drained(name, ok);
        random_ready = 1'b0;
    endtask

    initial begin
        int cycles;
        bit ok;
        void'($urandom(32'hc768));
        // Stretches of steady ready alternate with coin-flip ready
        for (int i = 0; i < PATTERN_LEN; i++) begin
            ready_pattern[i] = ((i / 64) % 2 == 0) ? 1'b1 : 1'($urandom % 2);
        end
        cycles = 0;
        while (reset_TX_RX_Block !== 1'b0 && cycles < 20) begin
            @(posedge user_clk);
            cycles++;
        end
        ok = (reset_TX_RX_Block === 1'b0);
        if (!ok) begin
            report_problem("reset was never released");
        end else begin
            quiet_check = 1'b1;   // Empty FIFO, so nothing may move for a while
            for (int i = 0; i < 20; i++) @(posedge user_clk);
            quiet_check = 1'b0;
            print_test_line("reset");

            queue_packet(8'h22, 1);         // Shortest packet, skips the payload state
            queue_packet(8'h22, 2);
            queue_packet(PARTNER_ID, 3);    // From the partner, dropped
            queue_packet(8'h35, 0);         // No payload, dropped
            queue_packet(8'h7e, 6);         // Full packet
            wait_drained("framing_and_drops", ok);
        end

        if (ok) run_random("random_ready_high", 40, 1'b0, ok);
        if (ok) run_random("random_backpressure", 60, 1'b1, ok);
        end_run();
    end

endmodule

// File: bench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,   // Full clock period
    parameter int RESET_CYCLES = 2     // Rising edges seen with reset high
) (
    output logic user_clk,
    output logic reset_TX_RX_Block
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        user_clk = 1'b0;
        forever #(PERIOD_NS / 2) user_clk = ~user_clk;
    end

    // Reset drops on a falling edge like every other DUT input
    initial begin
        reset_TX_RX_Block = 1'b1;
        repeat (RESET_CYCLES) @(posedge user_clk);
        @(negedge user_clk);
        reset_TX_RX_Block = 1'b0;
    end

endmodule

// File: common/framer_ctrl_if.sv
interface framer_ctrl_if;

    ////////////////////////////////////////////////////////////
    // Strobes from the sequencer
    ////////////////////////////////////////////////////////////

    logic load;          // Capture the head packet from the FIFO
    logic shift_en;      // Move the packet up one lane when the link is ready
    logic count_en;      // Step the word counter
    logic clear;         // Wipe the packet register, count and counter
    logic seq_advance;   // Bump the sequence number once per sent packet
    logic insert_seq;    // First beat carries the sequence number

    ////////////////////////////////////////////////////////////
    // Status back from the datapath
    ////////////////////////////////////////////////////////////

    logic drop_packet;   // Packet came from the partner, or it carries no payload
    logic single_word;   // Payload is exactly one word
    logic count_done;    // Word counter has reached the payload count

    // Sequencer side
    modport seq (
        output load, shift_en, count_en, clear, seq_advance, insert_seq,
        input  drop_packet, single_word, count_done
    );

    // Datapath side
    modport dp (
        input  load, shift_en, count_en, clear, seq_advance, insert_seq,
        output drop_packet, single_word, count_done
    );

endinterface

// File: common/framer_pkg.sv
package framer_pkg;

    ////////////////////////////////////////////////////////////
    // Lane and header geometry
    ////////////////////////////////////////////////////////////

    parameter int LANE_BITS   = 32;   // One beat on the single AXI-Stream lane
    parameter int HEADER_BITS = 64;   // Header takes two beats on the lane

    // One beat of transmitted data
    typedef logic [LANE_BITS-1:0] lane_word_t;

    typedef logic [7:0] seq_num_t;    // Packet sequence number, wraps after 255
    typedef logic [7:0] fpga_id_t;    // Source or target FPGA id

    // Payload length in 32-bit words
    // The valid-byte field always has its two low bits at zero, so they are dropped
    typedef logic [13:0] word_count_t;

    ////////////////////////////////////////////////////////////
    // Header field offsets, counted down from the packet MSB
    ////////////////////////////////////////////////////////////

    // Bus id byte, swapped for the sequence number on the link
    parameter int BUS_ID_OFS = 0;

    // Source FPGA id byte, compared against the link partner for broadcast loops
    parameter int SRC_ID_OFS = 8;

    // Valid-byte field is 16 bits wide here, only its upper 14 bits are taken
    parameter int COUNT_OFS  = 48;

endpackage

// File: framer/packet_datapath.sv
module packet_datapath #(
    parameter int                   PACKET_SIZE_BITS = 256,
    parameter framer_pkg::fpga_id_t TARGET_FPGA_ID   = 8'h01
) (
    input  logic                        user_clk,
    input  logic                        reset_TX_RX_Block,
    input  logic                        s_axi_tx_tready,
    input  logic [PACKET_SIZE_BITS-1:0] dout,        // Head packet of the FIFO
    framer_ctrl_if.dp                   ctrl,
    output framer_pkg::lane_word_t      stage_word   // Top lane of the packet register
);

    import framer_pkg::*;

    localparam int TOP = PACKET_SIZE_BITS - 1;

    // Header beats plus the most payload words a packet can hold
    localparam word_count_t WORD_CAPACITY =
        word_count_t'((PACKET_SIZE_BITS - HEADER_BITS) / LANE_BITS + 2);

    logic [PACKET_SIZE_BITS-1:0] pkt_q;   // Packet, shifted up one lane per beat
    logic                        load_q;  // Load one cycle ago
    logic                        insert_q;
    word_count_t                 count_q;     // Payload words of the current packet
    word_count_t                 word_cnt_q;  // Words stepped through so far
    seq_num_t                    seq_q;

    fpga_id_t    hdr_src_id;
    word_count_t hdr_count;
    lane_word_t  top_word;

    // Header fields read straight from the packet register
    assign hdr_src_id = pkt_q[TOP-SRC_ID_OFS -: $bits(fpga_id_t)];
    assign hdr_count  = pkt_q[TOP-COUNT_OFS -: $bits(word_count_t)];
    assign top_word   = pkt_q[TOP -: LANE_BITS];

    ////////////////////////////////////////////////////////////
    // Packet shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            pkt_q <= '0;
        end else if (ctrl.load) begin
            pkt_q <= dout;
        end else if (ctrl.shift_en && s_axi_tx_tready) begin
            // Next lane moves to the top, zeros fill from below
            pkt_q <= {pkt_q[TOP-LANE_BITS:0], {LANE_BITS{1'b0}}};
        end
    end

    ////////////////////////////////////////////////////////////
    // Count capture and word counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            count_q    <= '0;
            word_cnt_q <= '0;
        end else begin
            if (load_q) count_q <= hdr_count;   // Header settled in the register by now
            if (ctrl.count_en) word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    // Delayed strobes and the sequence number survive the per-packet clear
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            load_q   <= 1'b0;
            insert_q <= 1'b0;
            seq_q    <= '0;
        end else begin
            load_q   <= ctrl.load;
            insert_q <= ctrl.insert_seq;
            if (ctrl.seq_advance) seq_q <= seq_q + 1'b1;   // Wraps from 255 to 0
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus id swap and status flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        stage_word = top_word;
        // Receiver checks this byte for gaps in the packet stream
        if (insert_q) stage_word[LANE_BITS-1-BUS_ID_OFS -: $bits(seq_num_t)] = seq_q;
    end

    // Broadcast packets from the partner go no further, nor do empty ones
    assign ctrl.drop_packet = (hdr_src_id == TARGET_FPGA_ID) || (hdr_count == '0);
    assign ctrl.single_word = (count_q == word_count_t'(1));
    assign ctrl.count_done  = (word_cnt_q == count_q);

    a_cnt_capacity : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        word_cnt_q <= WORD_CAPACITY)
        else $error("word counter past packet capacity");

endmodule

// File: framer/tx_sequencer.sv
module tx_sequencer (
    input  logic              user_clk,
    input  logic              reset_TX_RX_Block,
    input  logic              empty,            // FIFO has no packet
    input  logic              s_axi_tx_tready,  // Link core accepts a beat
    framer_ctrl_if.seq        ctrl,
    output logic              rd_en,            // One-cycle pop of the head packet
    output logic              stage_valid,      // Beat handed to the pipeline is real
    output logic              stage_last        // Beat handed to the pipeline ends the packet
);

    typedef enum logic [2:0] {
        st_idle,          // Wait for a packet in the FIFO
        st_read,          // Capture dout into the packet register
        st_check,         // Decide whether the packet goes out at all
        st_drop_wait,     // Lets the FIFO pop settle before the next look at empty
        st_send_header0,
        st_send_header1,
        st_send_payload,
        st_send_last
    } state_t;

    state_t state_q;
    state_t state_d;

    logic empty_q;   // Registered copy of the FIFO empty flag
    logic rd_en_d;   // Pop request, goes out one cycle later

    ////////////////////////////////////////////////////////////
    // Registered FIFO flags and state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            empty_q <= 1'b1;   // Looks empty until the first real sample
            rd_en   <= 1'b0;
            state_q <= st_idle;
        end else begin
            empty_q <= empty;
            rd_en   <= rd_en_d;   // Lands one cycle after the load
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Quiet defaults, each state raises only what it needs
        state_d          = state_q;
        rd_en_d          = 1'b0;
        stage_valid      = 1'b0;
        stage_last       = 1'b0;
        ctrl.load        = 1'b0;
        ctrl.shift_en    = 1'b0;
        ctrl.count_en    = 1'b0;
        ctrl.clear       = 1'b0;
        ctrl.seq_advance = 1'b0;
        ctrl.insert_seq  = 1'b0;

        case (state_q)
            st_idle: begin
                ctrl.clear = 1'b1;   // Start every packet from a clean register
                if (!empty_q) state_d = st_read;
            end
            st_read: begin
                ctrl.load       = 1'b1;
                rd_en_d         = 1'b1;
                ctrl.insert_seq = 1'b1;   // Armed early so the first beat is ready
                state_d         = st_check;
            end
            st_check: begin
                ctrl.insert_seq = 1'b1;
                // Header is in the packet register now
                state_d = ctrl.drop_packet ? st_drop_wait : st_send_header0;
            end
            st_drop_wait: begin
                ctrl.clear = 1'b1;
                state_d    = st_idle;
            end
            st_send_header0: begin
                stage_valid     = 1'b1;
                ctrl.shift_en   = 1'b1;
                // Keep the sequence byte in place until this beat is taken
                ctrl.insert_seq = !s_axi_tx_tready;
                if (s_axi_tx_tready) state_d = st_send_header1;
            end
            st_send_header1: begin
                stage_valid   = 1'b1;
                ctrl.shift_en = 1'b1;
                ctrl.count_en = s_axi_tx_tready;   // Counter runs one ahead of the payload
                if (s_axi_tx_tready) begin
                    state_d = ctrl.single_word ? st_send_last : st_send_payload;
                end
            end
            st_send_payload: begin
                // All but the final payload word leave from here
                stage_valid   = !ctrl.count_done;
                ctrl.shift_en = !ctrl.count_done;
                ctrl.count_en = s_axi_tx_tready && !ctrl.count_done;
                // Counter only moves on ready, so no ready check is needed here
                if (ctrl.count_done) state_d = st_send_last;
            end
            st_send_last: begin
                stage_valid      = 1'b1;
                stage_last       = 1'b1;
                ctrl.seq_advance = s_axi_tx_tready;   // Next packet gets the next number
                if (s_axi_tx_tready) state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Each packet is popped exactly once
    a_rd_en_single : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        rd_en |=> !rd_en)
        else $error("rd_en high for two cycles in a row");

    a_last_valid : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        stage_last |-> stage_valid)
        else $error("stage_last without stage_valid");

endmodule

// File: sim.f
common/framer_pkg.sv
common/framer_ctrl_if.sv
src/tx_output_pipeline.sv
framer/tx_sequencer.sv
framer/packet_datapath.sv
src/aurora_tx_framer.sv
bench/tb_clock_gen.sv
bench/tb_aurora_tx_framer.sv

// File: src/aurora_tx_framer.sv
module aurora_tx_framer #(
    parameter int                   PACKET_SIZE_BITS = 256,   // 256, 512 or 1024
    parameter framer_pkg::fpga_id_t TARGET_FPGA_ID   = 8'h01  // FPGA on the far end
) (
    input  logic                        user_clk,
    input  logic                        reset_TX_RX_Block,

    // Show-ahead packet FIFO
    input  logic                        empty,
    output logic                        rd_en,
    input  logic [PACKET_SIZE_BITS-1:0] dout,

    // AXI-Stream lane into the link core
    output framer_pkg::lane_word_t      s_axi_tx_tdata,
    output logic                        s_axi_tx_tvalid,
    output logic                        s_axi_tx_tlast,
    input  logic                        s_axi_tx_tready
);

    import framer_pkg::*;

    lane_word_t stage_word;   // Beat leaving the datapath, before the pipeline
    logic       stage_valid;  // Beat qualifier from the sequencer
    logic       stage_last;   // Marks the final beat of a packet

    // Strobes and flags between the FSM and the datapath
    framer_ctrl_if ctrl ();

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    tx_sequencer u_sequencer (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .ctrl              (ctrl.seq),
        .rd_en             (rd_en),
        .stage_valid       (stage_valid),
        .stage_last        (stage_last)
    );

    ////////////////////////////////////////////////////////////
    // Packet storage and header rewrite
    ////////////////////////////////////////////////////////////

    packet_datapath #(
        .PACKET_SIZE_BITS (PACKET_SIZE_BITS),
        .TARGET_FPGA_ID   (TARGET_FPGA_ID)
    ) u_datapath (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .dout              (dout),
        .ctrl              (ctrl.dp),
        .stage_word        (stage_word)
    );

    // Three ready-gated register stages in front of the link core
    tx_output_pipeline u_pipeline (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .stage_word        (stage_word),
        .stage_valid       (stage_valid),
        .stage_last        (stage_last),
        .s_axi_tx_tdata    (s_axi_tx_tdata),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast)
    );

endmodule

// File: src/tx_output_pipeline.sv
module tx_output_pipeline (
    input  logic                   user_clk,
    input  logic                   reset_TX_RX_Block,
    input  logic                   s_axi_tx_tready,
    input  framer_pkg::lane_word_t stage_word,
    input  logic                   stage_valid,
    input  logic                   stage_last,
    output framer_pkg::lane_word_t s_axi_tx_tdata,
    output logic                   s_axi_tx_tvalid,
    output logic                   s_axi_tx_tlast
);

    import framer_pkg::*;

    localparam int NUM_STAGES = 3;

    lane_word_t                word_q [NUM_STAGES];
    logic [NUM_STAGES-1:0]     valid_q;
    logic [NUM_STAGES-1:0]     last_q;

    ////////////////////////////////////////////////////////////
    // Ready-gated stages
    ////////////////////////////////////////////////////////////

    // The link core may drop tready on any cycle
    // Every stage freezes together, so nothing in flight is lost
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                word_q[i] <= '0;
            end
            valid_q <= '0;
            last_q  <= '0;
        end else if (s_axi_tx_tready) begin
            word_q[0] <= stage_word;
            for (int i = 1; i < NUM_STAGES; i++) begin
                word_q[i] <= word_q[i-1];
            end
            valid_q <= {valid_q[NUM_STAGES-2:0], stage_valid};
            last_q  <= {last_q[NUM_STAGES-2:0], stage_last};
        end
    end

    assign s_axi_tx_tdata  = word_q[NUM_STAGES-1];
    assign s_axi_tx_tvalid = valid_q[NUM_STAGES-1];
    assign s_axi_tx_tlast  = last_q[NUM_STAGES-1];

    // A beat offered to the link stays put until it is taken
    a_hold_on_stall : assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        !s_axi_tx_tready |=> $stable(s_axi_tx_tdata) && $stable(s_axi_tx_tvalid)
                             && $stable(s_axi_tx_tlast))
        else $error("link outputs moved while tready was low");

endmodule
